// File: clint_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared definitions of the CLINT timer read path: address map,
// widths, AXI response codes, delay modes and the mtime union type
//////////////////////////////////////////////////////////////////////

package clint_pkg;

	// bus widths
	localparam int addr_len = 32;
	localparam int data_len = 32;

	// address map
	localparam logic [addr_len-1:0] clint_base    = 32'h0200_0000;
	localparam logic [addr_len-1:0] mtime_lo_addr = clint_base + 32'h0000_BFF8;
	localparam logic [addr_len-1:0] mtime_hi_addr = clint_base + 32'h0000_BFFC;

	// AXI read response codes
	localparam logic [1:0] resp_okay   = 2'd0;
	localparam logic [1:0] resp_slverr = 2'd2;

	// response delay
	localparam int delay_w = 4;
	localparam logic [delay_w-1:0] lfsr_seed = 4'b0001;

	// value 3 is not named and falls back to no delay
	typedef enum logic [1:0] {
		dly_none   = 2'd0,
		dly_fixed  = 2'd1,
		dly_random = 2'd2
	} delay_mode_t;

	// two 32-bit halves of mtime
	typedef struct packed {
		logic [data_len-1:0] hi;
		logic [data_len-1:0] lo;
	} mtime_words_t;

	// full count for the increment, word view for the read decode
	typedef union packed {
		logic [2*data_len-1:0] count;
		mtime_words_t          words;
	} mtime_u;

endpackage

// File: axi_rd_if.sv
//////////////////////////////////////////////////////////////////////
// AXI read address and read data channel bundle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface axi_rd_if;
	import clint_pkg::*;

	// address channel
	logic [addr_len-1:0] araddr;
	logic                arvalid;
	logic                arready;

	// data channel
	logic [data_len-1:0] rdata;
	logic [1:0]          rresp;
	logic                rvalid;
	logic                rlast;
	logic                rready;

	modport slave (
		input  araddr, arvalid, rready,
		output arready, rdata, rresp, rvalid, rlast
	);

	modport master (
		output araddr, arvalid, rready,
		input  arready, rdata, rresp, rvalid, rlast
	);

endinterface

// File: clint_timer.sv
//////////////////////////////////////////////////////////////////////
// free-running 64-bit mtime counter and read address decode
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module clint_timer (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic [clint_pkg::addr_len-1:0] addr_i,
	output logic [clint_pkg::data_len-1:0] word_o,
	output logic [1:0]                     resp_o
);
	import clint_pkg::*;

	mtime_u mtime_q;

	// counts every cycle, wraps at 2^64
	always_ff @(posedge clock) begin
		if (rstn) begin
			mtime_q.count <= '0;
		end else begin
			mtime_q.count <= mtime_q.count + 64'd1;
		end
	end

	// word select on the current address
	always_comb begin
		case (addr_i)
			mtime_lo_addr: begin
				word_o = mtime_q.words.lo;
				resp_o = resp_okay;
			end
			mtime_hi_addr: begin
				word_o = mtime_q.words.hi;
				resp_o = resp_okay;
			end
			default: begin
				// nothing else is mapped
				word_o = '0;
				resp_o = resp_slverr;
			end
		endcase
	end

endmodule

// File: read_latency_gen.sv
//////////////////////////////////////////////////////////////////////
// response delay generator: 4-bit LFSR and delay mode select,
// one registered delay per accepted read
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module read_latency_gen (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          accept_i,
	input  clint_pkg::delay_mode_t        mode_i,
	input  logic [clint_pkg::delay_w-1:0] fixed_delay_i,
	output logic [clint_pkg::delay_w-1:0] delay_o
);
	import clint_pkg::*;

	logic [delay_w-1:0] lfsr_q;
	logic [delay_w-1:0] delay_q;
	logic [delay_w-1:0] delay_sel;
	logic               feedback;

	// x^4 + x^3 + 1, never reaches zero from a nonzero seed
	assign feedback = lfsr_q[delay_w-1] ^ lfsr_q[delay_w-2];

	always_comb begin
		case (mode_i)
			dly_fixed:  delay_sel = fixed_delay_i;
			dly_random: delay_sel = lfsr_q;
			default:    delay_sel = '0;
		endcase
	end

	// lfsr advances once per accepted address
	always_ff @(posedge clock) begin
		if (rstn) begin
			lfsr_q  <= lfsr_seed;
			delay_q <= '0;
		end else if (accept_i) begin
			lfsr_q  <= {lfsr_q[delay_w-2:0], feedback};
			delay_q <= delay_sel;
		end
	end

	// held for the whole wait of the read
	assign delay_o = delay_q;

endmodule

// File: clint_read_slave.sv
//////////////////////////////////////////////////////////////////////
// AXI read channel slave: address accept, data capture,
// response delay count and response hold under back-pressure
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module clint_read_slave (
	input  logic                           clock,
	input  logic                           rstn,
	axi_rd_if.slave                        bus,
	input  logic [clint_pkg::data_len-1:0] word_i,
	input  logic [1:0]                     resp_i,
	input  logic [clint_pkg::delay_w-1:0]  delay_i,
	output logic                           accept_o
);
	import clint_pkg::*;

	typedef enum logic {
		wait_addr = 1'b0,
		wait_data = 1'b1
	} state_t;

	state_t              state_q;
	state_t              state_d;
	logic [delay_w-1:0]  wait_cnt_q;
	logic [data_len-1:0] rdata_q;
	logic [1:0]          rresp_q;
	logic                delay_reached;
	logic                resp_done;

	// handshakes
	assign accept_o  = bus.arvalid && bus.arready;
	assign resp_done = bus.rvalid && bus.rready;

	assign delay_reached = (wait_cnt_q == delay_i);

	// only one read in flight
	assign bus.arready = (state_q == wait_addr);
	assign bus.rvalid  = (state_q == wait_data) && delay_reached;
	assign bus.rlast   = bus.rvalid;
	assign bus.rdata   = rdata_q;
	assign bus.rresp   = rresp_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			wait_addr: begin
				if (accept_o) begin
					state_d = wait_data;
				end
			end
			wait_data: begin
				if (resp_done) begin
					state_d = wait_addr;
				end
			end
			default: begin
				state_d = wait_addr;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (rstn) begin
			state_q    <= wait_addr;
			wait_cnt_q <= '0;
		end else begin
			state_q <= state_d;
			// count stops at the delay so rvalid holds while stalled
			if (accept_o) begin
				wait_cnt_q <= '0;
			end else if ((state_q == wait_data) && !delay_reached) begin
				wait_cnt_q <= wait_cnt_q + delay_w'(1);
			end
		end
	end

	// data and response sampled at the address handshake
	always_ff @(posedge clock) begin
		if (accept_o) begin
			rdata_q <= word_i;
			rresp_q <= resp_i;
		end
	end

endmodule

// File: clint_subsys.sv
//////////////////////////////////////////////////////////////////////
// CLINT timer read subsystem top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module clint_subsys (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic [clint_pkg::addr_len-1:0] araddr_i,
	input  logic                           arvalid_i,
	output logic                           arready_o,
	output logic [clint_pkg::data_len-1:0] rdata_o,
	output logic [1:0]                     rresp_o,
	output logic                           rvalid_o,
	output logic                           rlast_o,
	input  logic                           rready_i,
	input  clint_pkg::delay_mode_t         delay_mode_i,
	input  logic [clint_pkg::delay_w-1:0]  fixed_delay_i
);
	import clint_pkg::*;

	axi_rd_if bus ();

	logic [data_len-1:0] word;
	logic [1:0]          resp;
	logic [delay_w-1:0]  delay;
	logic                accept;

	// top ports onto the master side of the bundle
	assign bus.araddr  = araddr_i;
	assign bus.arvalid = arvalid_i;
	assign bus.rready  = rready_i;
	assign arready_o   = bus.arready;
	assign rdata_o     = bus.rdata;
	assign rresp_o     = bus.rresp;
	assign rvalid_o    = bus.rvalid;
	assign rlast_o     = bus.rlast;

	clint_read_slave u_read_slave (
		.clock    (clock),
		.rstn     (rstn),
		.bus      (bus.slave),
		.word_i   (word),
		.resp_i   (resp),
		.delay_i  (delay),
		.accept_o (accept)
	);

	clint_timer u_timer (
		.clock  (clock),
		.rstn   (rstn),
		.addr_i (bus.araddr),
		.word_o (word),
		.resp_o (resp)
	);

	read_latency_gen u_latency_gen (
		.clock         (clock),
		.rstn          (rstn),
		.accept_i      (accept),
		.mode_i        (delay_mode_i),
		.fixed_delay_i (fixed_delay_i),
		.delay_o       (delay)
	);

endmodule

// File: tb_clint_subsys.sv
//////////////////////////////////////////////////////////////////////
// directed testbench for the CLINT timer read subsystem, with
// mtime and LFSR reference models and the read and compare tasks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_clint_subsys;
	import clint_pkg::*;

	localparam int wait_limit = 64;

	logic                clock;
	logic                rstn;
	logic [addr_len-1:0] araddr;
	logic                arvalid;
	logic                arready;
	logic [data_len-1:0] rdata;
	logic [1:0]          rresp;
	logic                rvalid;
	logic                rlast;
	logic                rready;
	delay_mode_t         delay_mode;
	logic [delay_w-1:0]  fixed_delay;

	longint      cycle_cnt;
	logic [31:0] rng_state;
	string       test_name;
	int          test_errs;
	int          total_errs;
	int          tests_run;
	int          tests_failed;

	clint_subsys dut (
		.clock         (clock),
		.rstn          (rstn),
		.araddr_i      (araddr),
		.arvalid_i     (arvalid),
		.arready_o     (arready),
		.rdata_o       (rdata),
		.rresp_o       (rresp),
		.rvalid_o      (rvalid),
		.rlast_o       (rlast),
		.rready_i      (rready),
		.delay_mode_i  (delay_mode),
		.fixed_delay_i (fixed_delay)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// expected mtime: edges seen since reset was released
	always @(posedge clock) begin
		if (rstn) begin
			cycle_cnt <= 0;
		end else begin
			cycle_cnt <= cycle_cnt + 1;
		end
	end

	always @(negedge clock) begin
		if (rlast !== rvalid) begin
			report_failure("rlast_o differs from rvalid_o");
		end
	end

	// xorshift32 source for delays, gaps and stalls
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// x^4 + x^3 + 1, shift left, feed bit3 ^ bit2
	function automatic logic [delay_w-1:0] lfsr_step(input logic [delay_w-1:0] v);
		return {v[2:0], v[3] ^ v[2]};
	endfunction

	task automatic report_failure(input string what);
		$display("ERROR in %s: %s", test_name, what);
		test_errs++;
	endtask

	task automatic give_up(input string what);
		$display("timeout in %s: %s gave up after %0d cycles", test_name, what, wait_limit);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	task automatic check_word(input string what, input logic [data_len-1:0] exp,
			input logic [data_len-1:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED %s %s: expected 0x%08h, actual 0x%08h",
				test_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_resp(input string what, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_latency(input string what, input int exp, input int act);
		if (act != exp) begin
			$display("CHECK FAILED %s %s: expected %0d cycles, actual %0d cycles",
				test_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		tests_run++;
		total_errs += test_errs;
		if (test_errs == 0) begin
			$display("%s: passed", test_name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", test_name, test_errs);
		end
	endtask

	// rstn high for 5 cycles, released on a falling edge
	task automatic apply_reset();
		rstn = 1'b1;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (5) begin
			@(negedge clock);
			if (arready !== 1'b1 || rvalid !== 1'b0) begin
				report_failure("wrong handshake outputs during reset");
			end
		end
		rstn = 1'b0;
	endtask

	// one read: count is mtime predicted for the handshake edge,
	// latency counts edges from that handshake to the first rvalid edge
	task automatic read_word(input logic [addr_len-1:0] addr, input int stall,
			input bit hold_ar, output logic [data_len-1:0] data, output logic [1:0] resp,
			output int latency, output longint count);
		int waited;
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b0;
		waited = 0;
		while (arready !== 1'b1) begin
			@(negedge clock);
			waited++;
			if (waited > wait_limit) begin
				give_up("wait for arready_o");
			end
		end
		count = cycle_cnt;
		@(negedge clock);
		if (!hold_ar) begin
			arvalid = 1'b0;
		end
		latency = 1;
		while (rvalid !== 1'b1) begin
			if (arready !== 1'b0) begin
				report_failure("arready_o high while a read is in flight");
			end
			@(negedge clock);
			latency++;
			if (latency > wait_limit) begin
				give_up("wait for rvalid_o");
			end
		end
		data = rdata;
		resp = rresp;
		// rready low: response must hold
		repeat (stall) begin
			@(negedge clock);
			if (rvalid !== 1'b1 || rdata !== data || rresp !== resp || arready !== 1'b0) begin
				report_failure("response changed or arready_o rose while rready_i was low");
			end
		end
		rready = 1'b1;
		@(negedge clock);
		rready = 1'b0;
		arvalid = 1'b0;
		if (arready !== 1'b1 || rvalid !== 1'b0) begin
			report_failure("slave not idle after the data handshake");
		end
	endtask

	task automatic reset_state();
		logic [data_len-1:0] data;
		logic [1:0]          resp;
		int                  lat;
		longint              count;
		start_test("reset_state");
		apply_reset();
		if (arready !== 1'b1 || rvalid !== 1'b0 || rlast !== 1'b0) begin
			report_failure("wrong handshake outputs in the first cycle after reset");
		end
		delay_mode = dly_none;
		read_word(mtime_lo_addr, 0, 1'b0, data, resp, lat, count);
		check_word("first mtime_lo", count[31:0], data);
		check_resp("first mtime_lo", resp_okay, resp);
		end_test();
	endtask

	task automatic mtime_words();
		logic [data_len-1:0] data;
		logic [1:0]          resp;
		int                  lat;
		longint              count;
		start_test("mtime_words");
		delay_mode = dly_none;
		for (int i = 0; i < 4; i++) begin
			repeat (int'(next_rand() % 4)) @(negedge clock);
			read_word(mtime_lo_addr, 0, 1'b0, data, resp, lat, count);
			check_word("mtime_lo", count[31:0], data);
			check_resp("mtime_lo", resp_okay, resp);
			check_latency("mtime_lo", 1, lat);
		end
		// count is far below 2^32 here
		read_word(mtime_hi_addr, 0, 1'b0, data, resp, lat, count);
		check_word("mtime_hi", 32'd0, data);
		check_resp("mtime_hi", resp_okay, resp);
		check_latency("mtime_hi", 1, lat);
		end_test();
	endtask

	task automatic bad_address();
		logic [addr_len-1:0] addrs [2];
		logic [data_len-1:0] data;
		logic [1:0]          resp;
		int                  lat;
		longint              count;
		start_test("bad_address");
		addrs[0] = clint_base;
		addrs[1] = mtime_hi_addr + 32'd4;
		for (int i = 0; i < 2; i++) begin
			read_word(addrs[i], 0, 1'b0, data, resp, lat, count);
			check_word("unmapped data", 32'd0, data);
			check_resp("unmapped resp", resp_slverr, resp);
		end
		end_test();
	endtask

	task automatic fixed_latency();
		logic [31:0]         rnd;
		logic [data_len-1:0] data;
		logic [1:0]          resp;
		int                  lat;
		longint              count;
		start_test("fixed_delay");
		delay_mode = dly_fixed;
		for (int i = 0; i < 5; i++) begin
			rnd = next_rand();
			fixed_delay = rnd[delay_w-1:0];
			read_word(mtime_lo_addr, 0, 1'b0, data, resp, lat, count);
			check_latency("fixed delay", int'(fixed_delay) + 1, lat);
			check_word("mtime_lo", count[31:0], data);
		end
		end_test();
	endtask

	task automatic random_latency();
		logic [delay_w-1:0]  model;
		logic [data_len-1:0] data;
		logic [1:0]          resp;
		int                  lat;
		longint              count;
		start_test("random_delay");
		apply_reset();
		delay_mode = dly_random;
		model = lfsr_seed;
		for (int i = 0; i < 8; i++) begin
			read_word(mtime_lo_addr, 0, 1'b0, data, resp, lat, count);
			check_latency("lfsr delay", int'(model) + 1, lat);
			check_word("mtime_lo", count[31:0], data);
			model = lfsr_step(model);
		end
		end_test();
	endtask

	// arvalid stays high through the stall, so an early accept would show
	task automatic backpressure();
		logic [data_len-1:0] data;
		logic [1:0]          resp;
		int                  lat;
		longint              count;
		start_test("backpressure");
		delay_mode = dly_fixed;
		fixed_delay = 4'd2;
		for (int i = 0; i < 4; i++) begin
			read_word(mtime_lo_addr, int'(next_rand() % 6) + 1, 1'b1, data, resp, lat, count);
			check_word("stalled mtime_lo", count[31:0], data);
			check_resp("stalled mtime_lo", resp_okay, resp);
			check_latency("stalled read", 3, lat);
		end
		end_test();
	endtask

	initial begin
		rstn = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		delay_mode = dly_none;
		fixed_delay = '0;
		rng_state = 32'd80;
		test_name = "startup";
		test_errs = 0;
		total_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		reset_state();
		mtime_words();
		bad_address();
		fixed_latency();
		random_latency();
		backpressure();
		$display("%0d tests run, %0d failed, %0d failed checks", tests_run, tests_failed,
			total_errs);
		if (total_errs == 0 && tests_failed == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: clint_subsys.f
clint_pkg.sv
axi_rd_if.sv
clint_timer.sv
read_latency_gen.sv
clint_read_slave.sv
clint_subsys.sv
tb_clint_subsys.sv
